/* rv_decoder.f */
+incdir+include
logic/rv_isa_pkg.sv
logic/field_extract.sv
logic/op_classify.sv
logic/rv_decoder.sv
bench/rv_decoder_assert.sv
bench/rv_decoder_tb.sv

/* Bender.yml */
package:
  name: rv_decoder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rv_isa_pkg.sv
      - logic/field_extract.sv
      - logic/op_classify.sv
      - logic/rv_decoder.sv
      - target: simulation
        files:
          - bench/rv_decoder_assert.sv
          - bench/rv_decoder_tb.sv

/* bench/rv_decoder_tb.sv */
// Stimulus only; the bound rv_decoder_assert does all checking and counts failures in fail_count
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_defs.svh"

module rv_decoder_tb;

    localparam int STIM_CYCLES = 500; // Roughly 475 cycles of tests
    localparam int MAX_CYCLES  = 4 * STIM_CYCLES;

    logic                     clk;
    logic                     reset;
    logic [`RV_ILEN-1:0]      instruction;
    logic                     decode_enable;
    logic [`RV_REG_W-1:0]     rd;
    logic [`RV_REG_W-1:0]     rs1;
    logic [`RV_REG_W-1:0]     rs2;
    logic [`RV_XLEN-1:0]      imm;
    logic [`RV_SHAMT_W-1:0]   shamt;
    logic [`RV_TYPE_W-1:0]    instruction_type;
    logic                     memory_access;
    logic                     decode_complete;

    int          fail_count  = 0;
    int          test_base   = 0;
    int          test_count  = 0;
    int          cycle_count = 0;
    logic [31:0] rand_state;
    logic [6:0]  kept_ops [9];

    rv_decoder dut_i (.*);

    bind rv_decoder rv_decoder_assert checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Random fields on a chosen opcode
    function automatic logic [31:0] word_with_op(input logic [6:0] op);
        logic [31:0] r;
        r = next_rand();
        return {r[31:7], op};
    endfunction

    task automatic drive(input logic [31:0] word, input logic en);
        @(posedge clk);
        #2;
        instruction   = word;
        decode_enable = en;
    endtask

    task automatic finish_test(input string name);
        repeat (3) drive('0, 1'b0); // Let the pipeline drain
        test_count++;
        $display("Test %0d %s: %0d failures", test_count, name, fail_count - test_base);
        test_base = fail_count;
    endtask

    initial begin
        logic [31:0] w;
        rand_state    = 32'ha1701113;
        kept_ops      = '{`RV_OP_OP, `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_BRANCH,
                          `RV_OP_JAL, `RV_OP_JALR, `RV_OP_LUI, `RV_OP_AUIPC};
        instruction   = '0;
        decode_enable = 1'b0;
        reset         = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (4) drive('0, 1'b0);
        finish_test("reset state");

        for (int f3 = 0; f3 < 8; f3++) begin
            w = word_with_op(`RV_OP_OP);
            drive({`RV_F7_BASE, w[24:15], f3[2:0], w[11:0]}, 1'b1);
            drive({`RV_F7_MULDIV, w[24:15], f3[2:0], w[11:0]}, 1'b1);
            drive({`RV_F7_ALT, w[24:15], f3[2:0], w[11:0]}, 1'b1); // SUB, SRA or unknown
            drive(w, 1'b1); // Random funct7
        end
        finish_test("register ops");

        for (int i = 0; i < 80; i++) begin
            drive(word_with_op(kept_ops[1 + i % 8]), 1'b1);
        end
        finish_test("immediate formats");

        for (int i = 0; i < 8; i++) begin
            w = next_rand();
            drive({`RV_SH_BASE, w[25:15], 3'b001, w[11:7], `RV_OP_OP_IMM}, 1'b1);
            drive({`RV_SH_BASE, w[25:15], 3'b101, w[11:7], `RV_OP_OP_IMM}, 1'b1);
            drive({`RV_SH_ALT, w[25:15], 3'b101, w[11:7], `RV_OP_OP_IMM}, 1'b1);
            drive({w[31:26] | 6'b100000, w[25:15], 3'b101, w[11:7], `RV_OP_OP_IMM}, 1'b1);
            drive(word_with_op(7'b0111011), 1'b1); // OP-32
            drive(word_with_op(7'b1110011), 1'b1); // SYSTEM
        end
        finish_test("shifts and unknown");

        for (int i = 0; i < 10; i++) begin
            drive(word_with_op(`RV_OP_LOAD), 1'b1);
            drive('0, 1'b1);                          // Zero word is ignored
            drive(word_with_op(`RV_OP_STORE), 1'b0);
            drive(word_with_op(`RV_OP_STORE), 1'b1);
        end
        finish_test("memory and ignored");

        for (int i = 0; i < 250; i++) begin
            w = next_rand();
            if (w[31:29] == 3'd0) begin
                drive(next_rand(), w[23:21] != 3'd0);
            end else begin
                drive(word_with_op(kept_ops[w[20:16] % 9]), w[23:21] != 3'd0);
            end
        end
        finish_test("random stream");

        $display("Tests run: %0d, failures: %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rv_decoder_assert.sv */
// Needs rv_decoder_tb.fail_count; fields are checked only on decode_complete, against the word 2 cycles back
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_defs.svh"

module rv_decoder_assert (
    input wire logic                   clk,
    input wire logic                   reset,
    input wire logic [`RV_ILEN-1:0]    instruction,
    input wire logic                   decode_enable,
    input wire logic [`RV_REG_W-1:0]   rd,
    input wire logic [`RV_REG_W-1:0]   rs1,
    input wire logic [`RV_REG_W-1:0]   rs2,
    input wire logic [`RV_XLEN-1:0]    imm,
    input wire logic [`RV_SHAMT_W-1:0] shamt,
    input wire logic [`RV_TYPE_W-1:0]  instruction_type,
    input wire logic                   memory_access,
    input wire logic                   decode_complete
);

    // Type code straight from the ISA encoding tables
    function automatic logic [7:0] ref_type(input logic [31:0] w);
        logic [2:0] f3;
        logic [7:0] base_tbl [8];
        logic [7:0] load_tbl [8];
        logic [7:0] branch_tbl [8];
        logic [7:0] imm_tbl [8];
        f3         = w[14:12];
        base_tbl   = '{`RV_T_ADD, `RV_T_SLL, `RV_T_SLT, `RV_T_SLTU,
                       `RV_T_XOR, `RV_T_SRL, `RV_T_OR, `RV_T_AND};
        load_tbl   = '{`RV_T_LB, `RV_T_LH, `RV_T_LW, `RV_T_LD,
                       `RV_T_LBU, `RV_T_LHU, `RV_T_LWU, `RV_T_UNKNOWN};
        branch_tbl = '{`RV_T_BEQ, `RV_T_BNE, `RV_T_UNKNOWN, `RV_T_UNKNOWN,
                       `RV_T_BLT, `RV_T_BGE, `RV_T_BLTU, `RV_T_BGEU};
        imm_tbl    = '{`RV_T_ADDI, `RV_T_UNKNOWN, `RV_T_SLTI, `RV_T_SLTIU,
                       `RV_T_XORI, `RV_T_UNKNOWN, `RV_T_ORI, `RV_T_ANDI};
        ref_type   = `RV_T_UNKNOWN;
        case (w[6:0])
            `RV_OP_OP: begin
                if (w[31:25] == `RV_F7_BASE) ref_type = base_tbl[f3];
                if (w[31:25] == `RV_F7_MULDIV) ref_type = `RV_T_MUL + f3; // M codes run in funct3 order
                if (w[31:25] == `RV_F7_ALT && f3 == 3'd0) ref_type = `RV_T_SUB;
                if (w[31:25] == `RV_F7_ALT && f3 == 3'd5) ref_type = `RV_T_SRA;
            end
            `RV_OP_OP_IMM: begin
                ref_type = imm_tbl[f3];
                if (f3 == 3'd1 && w[31:26] == 6'd0) ref_type = `RV_T_SLLI;
                if (f3 == 3'd5 && w[31:26] == 6'd0) ref_type = `RV_T_SRLI;
                if (f3 == 3'd5 && w[31:26] == 6'b010000) ref_type = `RV_T_SRAI;
            end
            `RV_OP_LOAD:   ref_type = load_tbl[f3];
            `RV_OP_STORE:  ref_type = (f3 < 3'd4) ? `RV_T_SB + f3 : `RV_T_UNKNOWN;
            `RV_OP_BRANCH: ref_type = branch_tbl[f3];
            `RV_OP_JAL:    ref_type = `RV_T_JAL;
            `RV_OP_JALR:   ref_type = `RV_T_JALR;
            `RV_OP_LUI:    ref_type = `RV_T_LUI;
            `RV_OP_AUIPC:  ref_type = `RV_T_AUIPC;
            default:       ref_type = `RV_T_UNKNOWN;
        endcase
    endfunction

    function automatic logic [63:0] ref_imm(input logic [31:0] w);
        case (w[6:0])
            `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR: ref_imm = {{52{w[31]}}, w[31:20]};
            `RV_OP_STORE:  ref_imm = {{52{w[31]}}, w[31:25], w[11:7]};
            `RV_OP_BRANCH: ref_imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            `RV_OP_LUI, `RV_OP_AUIPC: ref_imm = {{32{w[31]}}, w[31:12], 12'h000};
            `RV_OP_JAL:    ref_imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:       ref_imm = '0;
        endcase
    endfunction

    // rd, rs1, rs2 packed together, absent fields read as zero
    function automatic logic [14:0] ref_regs(input logic [31:0] w);
        logic has_rd;
        logic has_rs1;
        logic has_rs2;
        has_rd  = w[6:0] inside {`RV_OP_OP, `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR,
                                 `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL};
        has_rs1 = w[6:0] inside {`RV_OP_OP, `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR,
                                 `RV_OP_STORE, `RV_OP_BRANCH};
        has_rs2 = w[6:0] inside {`RV_OP_OP, `RV_OP_STORE, `RV_OP_BRANCH};
        return {has_rd ? w[11:7] : 5'd0, has_rs1 ? w[19:15] : 5'd0, has_rs2 ? w[24:20] : 5'd0};
    endfunction

    function automatic logic [5:0] ref_shamt(input logic [31:0] w);
        return (w[6:0] == `RV_OP_OP_IMM && w[13:12] == 2'b01) ? w[25:20] : 6'd0;
    endfunction

    complete_a: assert property (@(posedge clk) disable iff (reset)
        decode_complete == ($past(decode_enable && instruction != '0 && !reset, 2)
                            && !$past(reset)))
        else begin
            $error("** Error t=%0t decode_complete: expected %b, actual %b", $time,
                   $past(decode_enable && instruction != '0 && !reset, 2) && !$past(reset),
                   $sampled(decode_complete));
            rv_decoder_tb.fail_count++;
        end

    type_a: assert property (@(posedge clk) disable iff (reset)
        decode_complete |-> instruction_type == ref_type($past(instruction, 2)))
        else begin
            $error("** Error t=%0t instruction_type: expected %0d, actual %0d", $time,
                   ref_type($past(instruction, 2)), $sampled(instruction_type));
            rv_decoder_tb.fail_count++;
        end

    imm_a: assert property (@(posedge clk) disable iff (reset)
        decode_complete |-> imm == ref_imm($past(instruction, 2)))
        else begin
            $error("** Error t=%0t imm: expected %h, actual %h", $time,
                   ref_imm($past(instruction, 2)), $sampled(imm));
            rv_decoder_tb.fail_count++;
        end

    regs_a: assert property (@(posedge clk) disable iff (reset)
        decode_complete |-> {rd, rs1, rs2} == ref_regs($past(instruction, 2)))
        else begin
            $error("** Error t=%0t rd/rs1/rs2: expected %h, actual %h", $time,
                   ref_regs($past(instruction, 2)), $sampled({rd, rs1, rs2}));
            rv_decoder_tb.fail_count++;
        end

    shamt_a: assert property (@(posedge clk) disable iff (reset)
        decode_complete |-> shamt == ref_shamt($past(instruction, 2)))
        else begin
            $error("** Error t=%0t shamt: expected %0d, actual %0d", $time,
                   ref_shamt($past(instruction, 2)), $sampled(shamt));
            rv_decoder_tb.fail_count++;
        end

    mem_a: assert property (@(posedge clk) disable iff (reset)
        decode_complete |-> memory_access == ($past(instruction[6:0], 2) inside
                                              {`RV_OP_LOAD, `RV_OP_STORE}))
        else begin
            $error("** Error t=%0t memory_access: expected %b, actual %b", $time,
                   $past(instruction[6:0], 2) inside {`RV_OP_LOAD, `RV_OP_STORE},
                   $sampled(memory_access));
            rv_decoder_tb.fail_count++;
        end

    // Outputs cleared by reset, then held between pulses
    reset_clear_a: assert property (@(posedge clk) disable iff (reset)
        $fell(reset) |-> {rd, rs1, rs2, imm, shamt, instruction_type, memory_access} == '0)
        else begin
            $error("Output fields were not cleared by reset at t=%0t", $time);
            rv_decoder_tb.fail_count++;
        end

    hold_a: assert property (@(posedge clk) disable iff (reset)
        !decode_complete |-> $stable({rd, rs1, rs2, imm, shamt, instruction_type, memory_access}))
        else begin
            $error("Output fields changed without a decode_complete pulse at t=%0t", $time);
            rv_decoder_tb.fail_count++;
        end

endmodule

`default_nettype wire

/* logic/rv_decoder.sv */
// Two-stage RV64I+M decode; result pulses 2 cycles after acceptance, one word may enter per cycle
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_defs.svh"

module rv_decoder (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`RV_ILEN-1:0]    instruction,
    input  wire logic                   decode_enable,
    output logic [`RV_REG_W-1:0]        rd,
    output logic [`RV_REG_W-1:0]        rs1,
    output logic [`RV_REG_W-1:0]        rs2,
    output logic [`RV_XLEN-1:0]         imm,
    output logic [`RV_SHAMT_W-1:0]      shamt,
    output logic [`RV_TYPE_W-1:0]       instruction_type,
    output logic                        memory_access,
    output logic                        decode_complete
);

    logic                    s1_valid;
    rv_isa_pkg::instr_word_u s1_word;
    logic [`RV_REG_W-1:0]    s1_rd;
    logic [`RV_REG_W-1:0]    s1_rs1;
    logic [`RV_REG_W-1:0]    s1_rs2;
    logic [`RV_XLEN-1:0]     s1_imm;
    logic [`RV_SHAMT_W-1:0]  s1_shamt;

    field_extract field_extract_i (
        .clk(clk), .reset(reset),
        .instruction(instruction), .decode_enable(decode_enable),
        .s1_valid(s1_valid), .s1_word(s1_word),
        .s1_rd(s1_rd), .s1_rs1(s1_rs1), .s1_rs2(s1_rs2),
        .s1_imm(s1_imm), .s1_shamt(s1_shamt)
    );

    // Classification and output register
    op_classify op_classify_i (
        .clk(clk), .reset(reset),
        .s1_valid(s1_valid), .s1_word(s1_word),
        .s1_rd(s1_rd), .s1_rs1(s1_rs1), .s1_rs2(s1_rs2),
        .s1_imm(s1_imm), .s1_shamt(s1_shamt),
        .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .shamt(shamt),
        .instruction_type(instruction_type),
        .memory_access(memory_access),
        .decode_complete(decode_complete)
    );

endmodule

`default_nettype wire

/* logic/op_classify.sv */
// Second stage with no back-pressure, so outputs hold between complete pulses and must be taken on each pulse
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_defs.svh"

module op_classify (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       s1_valid,
    input  wire rv_isa_pkg::instr_word_u    s1_word,
    input  wire logic [`RV_REG_W-1:0]       s1_rd,
    input  wire logic [`RV_REG_W-1:0]       s1_rs1,
    input  wire logic [`RV_REG_W-1:0]       s1_rs2,
    input  wire logic [`RV_XLEN-1:0]        s1_imm,
    input  wire logic [`RV_SHAMT_W-1:0]     s1_shamt,
    output logic [`RV_REG_W-1:0]            rd,
    output logic [`RV_REG_W-1:0]            rs1,
    output logic [`RV_REG_W-1:0]            rs2,
    output logic [`RV_XLEN-1:0]             imm,
    output logic [`RV_SHAMT_W-1:0]          shamt,
    output logic [`RV_TYPE_W-1:0]           instruction_type,
    output logic                            memory_access,
    output logic                            decode_complete
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [5:0]            shift_hi;   // Bits 31:26 of an immediate shift
    logic [`RV_TYPE_W-1:0] type_next;
    logic                  mem_next;

    assign opcode   = s1_word.r_view.opcode;
    assign funct3   = s1_word.r_view.funct3;
    assign funct7   = s1_word.r_view.funct7;
    assign shift_hi = s1_word.i_view.imm12[11:6];

    assign mem_next = (opcode == `RV_OP_LOAD) || (opcode == `RV_OP_STORE);

    always_comb begin
        type_next = `RV_T_UNKNOWN;
        case (opcode)
            `RV_OP_OP: begin
                case (funct7)
                    `RV_F7_BASE: begin
                        case (funct3)
                            3'b000:  type_next = `RV_T_ADD;
                            3'b001:  type_next = `RV_T_SLL;
                            3'b010:  type_next = `RV_T_SLT;
                            3'b011:  type_next = `RV_T_SLTU;
                            3'b100:  type_next = `RV_T_XOR;
                            3'b101:  type_next = `RV_T_SRL;
                            3'b110:  type_next = `RV_T_OR;
                            default: type_next = `RV_T_AND;
                        endcase
                    end
                    `RV_F7_ALT: begin // Only SUB and SRA exist here
                        if (funct3 == 3'b000) begin
                            type_next = `RV_T_SUB;
                        end else if (funct3 == 3'b101) begin
                            type_next = `RV_T_SRA;
                        end
                    end
                    `RV_F7_MULDIV: begin
                        case (funct3)
                            3'b000:  type_next = `RV_T_MUL;
                            3'b001:  type_next = `RV_T_MULH;
                            3'b010:  type_next = `RV_T_MULHSU;
                            3'b011:  type_next = `RV_T_MULHU;
                            3'b100:  type_next = `RV_T_DIV;
                            3'b101:  type_next = `RV_T_DIVU;
                            3'b110:  type_next = `RV_T_REM;
                            default: type_next = `RV_T_REMU;
                        endcase
                    end
                    default: type_next = `RV_T_UNKNOWN;
                endcase
            end
            `RV_OP_OP_IMM: begin
                case (funct3)
                    3'b000: type_next = `RV_T_ADDI;
                    3'b010: type_next = `RV_T_SLTI;
                    3'b011: type_next = `RV_T_SLTIU;
                    3'b100: type_next = `RV_T_XORI;
                    3'b110: type_next = `RV_T_ORI;
                    3'b111: type_next = `RV_T_ANDI;
                    3'b001: begin
                        if (shift_hi == `RV_SH_BASE) type_next = `RV_T_SLLI;
                    end
                    default: begin // funct3 101 selects logical or arithmetic right
                        if (shift_hi == `RV_SH_BASE) begin
                            type_next = `RV_T_SRLI;
                        end else if (shift_hi == `RV_SH_ALT) begin
                            type_next = `RV_T_SRAI;
                        end
                    end
                endcase
            end
            `RV_OP_LOAD: begin
                case (funct3)
                    3'b000:  type_next = `RV_T_LB;
                    3'b001:  type_next = `RV_T_LH;
                    3'b010:  type_next = `RV_T_LW;
                    3'b011:  type_next = `RV_T_LD;
                    3'b100:  type_next = `RV_T_LBU;
                    3'b101:  type_next = `RV_T_LHU;
                    3'b110:  type_next = `RV_T_LWU;
                    default: type_next = `RV_T_UNKNOWN; // 111 is reserved
                endcase
            end
            `RV_OP_STORE: begin
                case (funct3)
                    3'b000:  type_next = `RV_T_SB;
                    3'b001:  type_next = `RV_T_SH;
                    3'b010:  type_next = `RV_T_SW;
                    3'b011:  type_next = `RV_T_SD;
                    default: type_next = `RV_T_UNKNOWN;
                endcase
            end
            `RV_OP_BRANCH: begin
                case (funct3)
                    3'b000:  type_next = `RV_T_BEQ;
                    3'b001:  type_next = `RV_T_BNE;
                    3'b100:  type_next = `RV_T_BLT;
                    3'b101:  type_next = `RV_T_BGE;
                    3'b110:  type_next = `RV_T_BLTU;
                    3'b111:  type_next = `RV_T_BGEU;
                    default: type_next = `RV_T_UNKNOWN;
                endcase
            end
            `RV_OP_JAL:   type_next = `RV_T_JAL;
            `RV_OP_JALR:  type_next = `RV_T_JALR;  // funct3 not checked
            `RV_OP_LUI:   type_next = `RV_T_LUI;
            `RV_OP_AUIPC: type_next = `RV_T_AUIPC;
            default:      type_next = `RV_T_UNKNOWN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd               <= '0;
            rs1              <= '0;
            rs2              <= '0;
            imm              <= '0;
            shamt            <= '0;
            instruction_type <= '0;
            memory_access    <= 1'b0;
            decode_complete  <= 1'b0;
        end else begin
            decode_complete <= s1_valid; // One pulse per stage-1 word
            if (s1_valid) begin
                rd               <= s1_rd;
                rs1              <= s1_rs1;
                rs2              <= s1_rs2;
                imm              <= s1_imm;
                shamt            <= s1_shamt;
                instruction_type <= type_next;
                memory_access    <= mem_next;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/field_extract.sv */
// Stage 1: all-zero words and low enable are dropped; foreign opcodes leave every field zero
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_defs.svh"

module field_extract (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [`RV_ILEN-1:0]        instruction,
    input  wire logic                       decode_enable,
    output logic                            s1_valid,
    output rv_isa_pkg::instr_word_u         s1_word,
    output logic [`RV_REG_W-1:0]            s1_rd,
    output logic [`RV_REG_W-1:0]            s1_rs1,
    output logic [`RV_REG_W-1:0]            s1_rs2,
    output logic [`RV_XLEN-1:0]             s1_imm,
    output logic [`RV_SHAMT_W-1:0]          s1_shamt
);

    rv_isa_pkg::instr_word_u word;
    logic                    accept;

    logic [`RV_XLEN-1:0]     imm_i;
    logic [`RV_XLEN-1:0]     imm_s;
    logic [`RV_XLEN-1:0]     imm_b;
    logic [`RV_XLEN-1:0]     imm_u;
    logic [`RV_XLEN-1:0]     imm_j;

    logic [`RV_REG_W-1:0]    rd_next;
    logic [`RV_REG_W-1:0]    rs1_next;
    logic [`RV_REG_W-1:0]    rs2_next;
    logic [`RV_XLEN-1:0]     imm_next;
    logic [`RV_SHAMT_W-1:0]  shamt_next;

    assign word   = instruction;
    assign accept = decode_enable && (instruction != '0);

    // Every format sign-extends from bit 31
    assign imm_i = {{(`RV_XLEN-12){instruction[31]}}, word.i_view.imm12};
    assign imm_s = {{(`RV_XLEN-12){instruction[31]}}, word.s_view.imm_hi, word.s_view.imm_lo};
    assign imm_b = {{(`RV_XLEN-13){instruction[31]}}, word.s_view.imm_hi[6],
                    word.s_view.imm_lo[0], word.s_view.imm_hi[5:0],
                    word.s_view.imm_lo[4:1], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){instruction[31]}}, instruction[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){instruction[31]}}, instruction[31],
                    instruction[19:12], instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        rd_next    = '0;
        rs1_next   = '0;
        rs2_next   = '0;
        imm_next   = '0;
        shamt_next = '0;

        case (word.r_view.opcode)
            `RV_OP_OP: begin // R form, no immediate
                rd_next  = word.r_view.rd;
                rs1_next = word.r_view.rs1;
                rs2_next = word.r_view.rs2;
            end
            `RV_OP_OP_IMM: begin
                rd_next  = word.i_view.rd;
                rs1_next = word.i_view.rs1;
                imm_next = imm_i;
                // SLLI, SRLI and SRAI carry a 6-bit shift amount
                if (word.i_view.funct3 == 3'b001 || word.i_view.funct3 == 3'b101) begin
                    shamt_next = word.i_view.imm12[`RV_SHAMT_W-1:0];
                end
            end
            `RV_OP_LOAD, `RV_OP_JALR: begin
                rd_next  = word.i_view.rd;
                rs1_next = word.i_view.rs1;
                imm_next = imm_i;
            end
            `RV_OP_STORE: begin
                rs1_next = word.s_view.rs1;
                rs2_next = word.s_view.rs2;
                imm_next = imm_s;
            end
            `RV_OP_BRANCH: begin
                rs1_next = word.s_view.rs1;
                rs2_next = word.s_view.rs2;
                imm_next = imm_b;
            end
            `RV_OP_LUI, `RV_OP_AUIPC: begin
                rd_next  = word.r_view.rd;
                imm_next = imm_u;
            end
            `RV_OP_JAL: begin
                rd_next  = word.r_view.rd;
                imm_next = imm_j;
            end
            default: imm_next = '0; // Unknown opcode keeps all fields clear
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    // Payload only moves on an accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_word  <= word;
            s1_rd    <= rd_next;
            s1_rs1   <= rs1_next;
            s1_rs2   <= rs2_next;
            s1_imm   <= imm_next;
            s1_shamt <= shamt_next;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_isa_pkg.sv */
// Views of one 32-bit RISC-V word; only R, I and S layouts, B/U/J are sliced from these or the raw word
`default_nettype none

`include "rv_decoder_defs.svh"

package rv_isa_pkg;

    // Same 32 bits, three standard layouts
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [`RV_REG_W-1:0] rs2;
            logic [`RV_REG_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [`RV_REG_W-1:0] rd;
            logic [6:0]           opcode;
        } r_view;
        struct packed {
            logic [11:0]          imm12;   // Also holds shift amount and shift kind
            logic [`RV_REG_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [`RV_REG_W-1:0] rd;
            logic [6:0]           opcode;
        } i_view;
        struct packed {
            logic [6:0]           imm_hi;  // Imm 11:5, B form reuses it
            logic [`RV_REG_W-1:0] rs2;
            logic [`RV_REG_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_lo;  // Imm 4:0
            logic [6:0]           opcode;
        } s_view;
    } instr_word_u;

endpackage

`default_nettype wire

/* include/rv_decoder_defs.svh */
// RV64I+M decoder constants; type codes follow the existing decoder table, W forms and SYSTEM are not covered
`ifndef RV_DECODER_DEFS_SVH
`define RV_DECODER_DEFS_SVH

// Datapath widths
`define RV_ILEN     32
`define RV_XLEN     64
`define RV_REG_W    5
`define RV_SHAMT_W  6 // RV64 immediate shifts only
`define RV_TYPE_W   8

// Major opcodes, instruction bits 6:0
`define RV_OP_OP      7'b0110011
`define RV_OP_OP_IMM  7'b0010011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111

// funct7 groups for OP
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000 // SUB and SRA
`define RV_F7_MULDIV  7'b0000001

// Upper six bits of an immediate shift, instruction bits 31:26
`define RV_SH_BASE    6'b000000
`define RV_SH_ALT     6'b010000 // SRAI

// Register-register base ops
`define RV_T_ADD      8'd0
`define RV_T_SUB      8'd1
`define RV_T_XOR      8'd2
`define RV_T_OR       8'd3
`define RV_T_AND      8'd4
`define RV_T_SLL      8'd5
`define RV_T_SRL      8'd6
`define RV_T_SRA      8'd7
`define RV_T_SLT      8'd8
`define RV_T_SLTU     8'd9

// M extension
`define RV_T_MUL      8'd10
`define RV_T_MULH     8'd11
`define RV_T_MULHSU   8'd12
`define RV_T_MULHU    8'd13
`define RV_T_DIV      8'd14
`define RV_T_DIVU     8'd15
`define RV_T_REM      8'd16
`define RV_T_REMU     8'd17

// Register-immediate ops
`define RV_T_ADDI     8'd18
`define RV_T_XORI     8'd19
`define RV_T_ORI      8'd20
`define RV_T_ANDI     8'd21
`define RV_T_SLLI     8'd22
`define RV_T_SRLI     8'd23
`define RV_T_SRAI     8'd24
`define RV_T_SLTI     8'd25
`define RV_T_SLTIU    8'd26

// Stores and branches
`define RV_T_SB       8'd43
`define RV_T_SH       8'd44
`define RV_T_SW       8'd45
`define RV_T_SD       8'd46
`define RV_T_BEQ      8'd47
`define RV_T_BNE      8'd48
`define RV_T_BLT      8'd49
`define RV_T_BGE      8'd50
`define RV_T_BLTU     8'd51
`define RV_T_BGEU     8'd52

// Jumps and upper immediates
`define RV_T_JAL      8'd53
`define RV_T_JALR     8'd54
`define RV_T_LUI      8'd55
`define RV_T_AUIPC    8'd56

// Loads
`define RV_T_LB       8'd59
`define RV_T_LH       8'd60
`define RV_T_LW       8'd61
`define RV_T_LBU      8'd62
`define RV_T_LHU      8'd63
`define RV_T_LWU      8'd64
`define RV_T_LD       8'd65

`define RV_T_UNKNOWN  8'hFF // Anything outside the tables above

`endif
